// File: all.f
common/stream_pkg.sv
common/hash2qid_pkg.sv
hash2qid/hash2qid_reg_blk.sv
hash2qid/hash2qid_lookup.sv
src/hash2qid_top.sv
test/hash2qid_tb.sv

// File: Bender.yml
package:
  name: hash2qid

sources:
  # shared packages
  - common/stream_pkg.sv
  - common/hash2qid_pkg.sv
  # design
  - hash2qid/hash2qid_reg_blk.sv
  - hash2qid/hash2qid_lookup.sv
  - src/hash2qid_top.sv
  # testbench
  - target: test
    files:
      - test/hash2qid_tb.sv

// File: test/hash2qid_tb.sv
module hash2qid_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 40;

    // about 3100 cycles of register traffic plus about 400 beats
    // of a few cycles each under back-pressure leaves a wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    // one expected output beat
    typedef struct packed {
        logic [stream_pkg::DATA_WID-1:0]    data;
        logic [stream_pkg::KEEP_WID-1:0]    keep;
        logic                               last;
        logic [stream_pkg::TID_WID-1:0]     id;
        logic [stream_pkg::TDEST_WID-1:0]   dest;
        logic [stream_pkg::ENTROPY_WID-1:0] entropy;
    } beat_t;

    logic                                   core_clk;
    logic                                   reset;
    logic                                   reg_wr;
    logic                                   reg_rd;
    logic [hash2qid_pkg::REG_ADDR_WID-1:0]  reg_addr;
    logic [hash2qid_pkg::QID_WID-1:0]       reg_wdata;
    logic [hash2qid_pkg::QID_WID-1:0]       reg_rdata;
    logic                                   reg_rack;
    logic                                   in_tvalid;
    logic                                   in_tready;
    logic [stream_pkg::DATA_WID-1:0]        in_tdata;
    logic [stream_pkg::KEEP_WID-1:0]        in_tkeep;
    logic                                   in_tlast;
    logic [stream_pkg::TID_WID-1:0]         in_tid;
    logic [stream_pkg::TDEST_WID-1:0]       in_tdest;
    logic                                   in_rss_enable;
    logic [stream_pkg::ENTROPY_WID-1:0]     in_rss_entropy;
    logic                                   out_tvalid;
    logic                                   out_tready;
    logic [stream_pkg::DATA_WID-1:0]        out_tdata;
    logic [stream_pkg::KEEP_WID-1:0]        out_tkeep;
    logic                                   out_tlast;
    logic [stream_pkg::TID_WID-1:0]         out_tid;
    logic [stream_pkg::TDEST_WID-1:0]       out_tdest;
    logic                                   out_rss_enable;
    logic [stream_pkg::ENTROPY_WID-1:0]     out_rss_entropy;

    integer seed;
    int     err_cnt;
    int     check_cnt;
    int     sent_cnt;
    int     recv_cnt;
    int     cycle_cnt;
    logic   ready_random;

    // shadow copy of the register contents
    logic [hash2qid_pkg::QID_WID-1:0] shadow_tbl [4][128];
    logic [hash2qid_pkg::QID_WID-1:0] shadow_base [4];

    // beats accepted but not yet seen on the output
    beat_t exp_q [$];

    hash2qid_top UUT (
        .core_clk        (core_clk),
        .reset           (reset),
        .reg_wr          (reg_wr),
        .reg_rd          (reg_rd),
        .reg_addr        (reg_addr),
        .reg_wdata       (reg_wdata),
        .reg_rdata       (reg_rdata),
        .reg_rack        (reg_rack),
        .in_tvalid       (in_tvalid),
        .in_tready       (in_tready),
        .in_tdata        (in_tdata),
        .in_tkeep        (in_tkeep),
        .in_tlast        (in_tlast),
        .in_tid          (in_tid),
        .in_tdest        (in_tdest),
        .in_rss_enable   (in_rss_enable),
        .in_rss_entropy  (in_rss_entropy),
        .out_tvalid      (out_tvalid),
        .out_tready      (out_tready),
        .out_tdata       (out_tdata),
        .out_tkeep       (out_tkeep),
        .out_tlast       (out_tlast),
        .out_tid         (out_tid),
        .out_tdest       (out_tdest),
        .out_rss_enable  (out_rss_enable),
        .out_rss_entropy (out_rss_entropy)
    );

    initial begin
        core_clk = 1'b0;
        forever #(CLK_PERIOD / 2) core_clk = ~core_clk;
    end

    // run limit
    always @(posedge core_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // ------------------------------
    // checking helpers
    // ------------------------------

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
        check_cnt++;
        if (exp !== got) begin
            err_cnt++;
            $display("[ERROR] %0d ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic report_problem(input string msg);
        err_cnt++;
        $display("%0d ns: %s", $time, msg);
    endtask

    // table entry plus interface base with 12-bit wrap
    function automatic logic [11:0] expected_entropy(input logic rss_en,
                                                      input logic [11:0] ent);
        logic [11:0] qid;
        qid = rss_en ? shadow_tbl[ent[11:10]][ent[6:0]] : 12'h000;
        return qid + shadow_base[ent[11:10]];
    endfunction

    function automatic logic [9:0] table_addr(input int host, input int idx);
        logic [9:0] base;
        case (host)
            0:       base = hash2qid_pkg::PF_TABLE_BASE;
            1:       base = hash2qid_pkg::VF0_TABLE_BASE;
            2:       base = hash2qid_pkg::VF1_TABLE_BASE;
            default: base = hash2qid_pkg::VF2_TABLE_BASE;
        endcase
        return base + 10'(idx);
    endfunction

    task automatic check_output();
        beat_t exp;
        recv_cnt++;
        check_value("out_rss_enable", 64'd1, out_rss_enable);
        if (exp_q.size() == 0) begin
            report_problem("an output beat arrived while no beat was expected");
        end else begin
            exp = exp_q.pop_front();
            check_value("out_tdata", exp.data, out_tdata);
            check_value("out_tkeep", exp.keep, out_tkeep);
            check_value("out_tlast", exp.last, out_tlast);
            check_value("out_tid", exp.id, out_tid);
            check_value("out_tdest", exp.dest, out_tdest);
            check_value("out_rss_entropy", exp.entropy, out_rss_entropy);
        end
    endtask

    // scoreboard fills on acceptance and drains on output transfer
    always @(posedge core_clk) begin : monitor
        beat_t b;
        if (!reset) begin
            if (in_tvalid && in_tready) begin
                b.data    = in_tdata;
                b.keep    = in_tkeep;
                b.last    = in_tlast;
                b.id      = in_tid;
                b.dest    = in_tdest;
                b.entropy = expected_entropy(in_rss_enable, in_rss_entropy);
                exp_q.push_back(b);
                sent_cnt++;
            end
            if (out_tvalid && out_tready) begin
                check_output();
            end
        end
    end

    // ------------------------------
    // bus and stream drivers
    // ------------------------------

    task automatic reg_write(input logic [9:0] addr, input logic [11:0] data);
        @(negedge core_clk);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge core_clk);
        reg_wr = 1'b0;
    endtask

    task automatic reg_read(input logic [9:0] addr, output logic [11:0] data);
        @(negedge core_clk);
        // also shows the previous acknowledge lasted one cycle
        if (reg_rack !== 1'b0) begin
            report_problem("read acknowledge was high before the read strobe");
        end
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(negedge core_clk);
        reg_rd = 1'b0;
        if (reg_rack !== 1'b1) begin
            report_problem("read acknowledge missing one cycle after the read strobe");
        end
        data = reg_rdata;
    endtask

    task automatic next_cycle();
        int r;
        @(negedge core_clk);
        if (ready_random) begin
            r = $random(seed);
            out_tready = r[0] | r[1];
        end
    endtask

    // rss_mode 0 disables rss, 1 enables it and 2 picks at random
    task automatic send_beat(input int rss_mode, input int gap_max);
        int   r;
        int   gap;
        logic accepted;
        r   = $random(seed);
        gap = (gap_max > 0) ? int'(r[7:0]) % (gap_max + 1) : 0;
        repeat (gap) begin
            next_cycle();
            in_tvalid = 1'b0;
        end
        next_cycle();
        r              = $random(seed);
        in_tvalid      = 1'b1;
        in_tdata       = {$random(seed), $random(seed)};
        in_tkeep       = r[7:0];
        in_tlast       = r[8];
        in_tid         = r[12:9];
        in_tdest       = r[16:13];
        in_rss_enable  = (rss_mode == 2) ? r[17] : (rss_mode == 1);
        in_rss_entropy = $random(seed);
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge core_clk);
            if (in_tready) begin
                accepted = 1'b1;
            end else begin
                next_cycle();
            end
        end
    endtask

    task automatic end_stream();
        next_cycle();
        in_tvalid = 1'b0;
        while (exp_q.size() != 0) begin
            next_cycle();
        end
        ready_random = 1'b0;
        out_tready   = 1'b1;
    endtask

    // ------------------------------
    // tests
    // ------------------------------

    task automatic reset_values();
        @(negedge core_clk);
        check_value("out_tvalid", 64'd0, out_tvalid);
        check_value("reg_rack", 64'd0, reg_rack);
        check_value("in_tready", 64'd1, in_tready);
        out_tready = 1'b1;
    endtask

    task automatic verify_registers();
        logic [11:0] d;
        for (int h = 0; h < 4; h++) begin
            for (int i = 0; i < 128; i++) begin
                reg_read(table_addr(h, i), d);
                check_value($sformatf("reg_rdata @%h", table_addr(h, i)), shadow_tbl[h][i], d);
            end
            reg_read(hash2qid_pkg::Q_BASE_ADDR + 10'(h), d);
            check_value($sformatf("reg_rdata @%h", hash2qid_pkg::Q_BASE_ADDR + 10'(h)),
                        shadow_base[h], d);
        end
    endtask

    task automatic register_readback();
        int r;
        for (int h = 0; h < 4; h++) begin
            for (int i = 0; i < 128; i++) begin
                r = $random(seed);
                shadow_tbl[h][i] = r[11:0];
                reg_write(table_addr(h, i), r[11:0]);
            end
            r = $random(seed);
            shadow_base[h] = r[11:0];
            reg_write(hash2qid_pkg::Q_BASE_ADDR + 10'(h), r[11:0]);
        end
        verify_registers();
    endtask

    task automatic unmapped_access();
        logic [9:0]  addr [4];
        logic [11:0] d;
        int          r;
        r       = $random(seed);
        addr[0] = 10'h204;
        addr[1] = 10'h2a5;
        addr[2] = 10'h3ff;
        // anywhere above the base registers
        addr[3] = 10'h204 + 10'(int'(r[8:0]) % 508);
        for (int k = 0; k < 4; k++) begin
            r = $random(seed);
            reg_write(addr[k], r[11:0] | 12'h001);
            reg_read(addr[k], d);
            check_value($sformatf("reg_rdata @%h", addr[k]), 64'd0, d);
        end
        verify_registers();
    endtask

    task automatic rss_mapping();
        repeat (120) send_beat(1, 0);
        end_stream();
    endtask

    task automatic rss_disabled_beats();
        repeat (60) send_beat(0, 1);
        end_stream();
    endtask

    // random stalls on both sides
    task automatic random_stall_stream();
        ready_random = 1'b1;
        repeat (220) send_beat(2, 2);
        end_stream();
    endtask

    task automatic single_beat_latency();
        int edges;
        next_cycle();
        in_tvalid      = 1'b1;
        in_rss_enable  = 1'b1;
        in_rss_entropy = $random(seed);
        @(posedge core_clk);
        if (!in_tready) begin
            report_problem("single beat was not accepted by an empty pipeline");
        end
        next_cycle();
        in_tvalid = 1'b0;
        edges = 0;
        while (edges < 20 && !(out_tvalid && out_tready)) begin
            @(posedge core_clk);
            edges++;
        end
        check_value("latency", 64'd3, edges);
        end_stream();
    endtask

    initial begin
        seed           = 32'hdd0a;
        err_cnt        = 0;
        check_cnt      = 0;
        sent_cnt       = 0;
        recv_cnt       = 0;
        cycle_cnt      = 0;
        ready_random   = 1'b0;
        reset          = 1'b1;
        reg_wr         = 1'b0;
        reg_rd         = 1'b0;
        reg_addr       = '0;
        reg_wdata      = '0;
        in_tvalid      = 1'b0;
        in_tdata       = '0;
        in_tkeep       = '0;
        in_tlast       = 1'b0;
        in_tid         = '0;
        in_tdest       = '0;
        in_rss_enable  = 1'b0;
        in_rss_entropy = '0;
        out_tready     = 1'b0;

        repeat (5) @(posedge core_clk);
        @(negedge core_clk);
        reset = 1'b0;

        reset_values();
        register_readback();
        unmapped_access();
        rss_mapping();
        rss_disabled_beats();
        random_stall_stream();
        single_beat_latency();

        if (sent_cnt != recv_cnt) begin
            report_problem("number of beats sent and received differ");
        end
        $display("checks: %0d, errors: %0d, beats sent: %0d, beats received: %0d",
                 check_cnt, err_cnt, sent_cnt, recv_cnt);
        if (err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: src/hash2qid_top.sv
module hash2qid_top (
    input  logic                                  core_clk,
    input  logic                                  reset,

    // register bus
    input  logic                                  reg_wr,
    input  logic                                  reg_rd,
    input  logic [hash2qid_pkg::REG_ADDR_WID-1:0] reg_addr,
    input  logic [hash2qid_pkg::QID_WID-1:0]      reg_wdata,
    output logic [hash2qid_pkg::QID_WID-1:0]      reg_rdata,
    output logic                                  reg_rack,

    // input stream
    input  logic                                  in_tvalid,
    output logic                                  in_tready,
    input  logic [stream_pkg::DATA_WID-1:0]       in_tdata,
    input  logic [stream_pkg::KEEP_WID-1:0]       in_tkeep,
    input  logic                                  in_tlast,
    input  logic [stream_pkg::TID_WID-1:0]        in_tid,
    input  logic [stream_pkg::TDEST_WID-1:0]      in_tdest,
    input  logic                                  in_rss_enable,
    input  logic [stream_pkg::ENTROPY_WID-1:0]    in_rss_entropy,

    // output stream
    output logic                                  out_tvalid,
    input  logic                                  out_tready,
    output logic [stream_pkg::DATA_WID-1:0]       out_tdata,
    output logic [stream_pkg::KEEP_WID-1:0]       out_tkeep,
    output logic                                  out_tlast,
    output logic [stream_pkg::TID_WID-1:0]        out_tid,
    output logic [stream_pkg::TDEST_WID-1:0]      out_tdest,
    output logic                                  out_rss_enable,
    output logic [stream_pkg::ENTROPY_WID-1:0]    out_rss_entropy
);

    // table read index from the pipeline
    logic [hash2qid_pkg::TABLE_IDX_WID-1:0] tbl_idx;

    // candidate queue ids at tbl_idx
    logic [hash2qid_pkg::QID_WID-1:0] pf_qid;
    logic [hash2qid_pkg::QID_WID-1:0] vf0_qid;
    logic [hash2qid_pkg::QID_WID-1:0] vf1_qid;
    logic [hash2qid_pkg::QID_WID-1:0] vf2_qid;

    // per-interface offsets
    logic [hash2qid_pkg::QID_WID-1:0] base_pf;
    logic [hash2qid_pkg::QID_WID-1:0] base_vf0;
    logic [hash2qid_pkg::QID_WID-1:0] base_vf1;
    logic [hash2qid_pkg::QID_WID-1:0] base_vf2;

    hash2qid_reg_blk reg_blk_0 (
        .core_clk  (core_clk),
        .reset     (reset),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .reg_rack  (reg_rack),
        .tbl_idx   (tbl_idx),
        .pf_qid    (pf_qid),
        .vf0_qid   (vf0_qid),
        .vf1_qid   (vf1_qid),
        .vf2_qid   (vf2_qid),
        .base_pf   (base_pf),
        .base_vf0  (base_vf0),
        .base_vf1  (base_vf1),
        .base_vf2  (base_vf2)
    );

    hash2qid_lookup lookup_0 (
        .core_clk        (core_clk),
        .reset           (reset),
        .in_tvalid       (in_tvalid),
        .in_tready       (in_tready),
        .in_tdata        (in_tdata),
        .in_tkeep        (in_tkeep),
        .in_tlast        (in_tlast),
        .in_tid          (in_tid),
        .in_tdest        (in_tdest),
        .in_rss_enable   (in_rss_enable),
        .in_rss_entropy  (in_rss_entropy),
        .out_tvalid      (out_tvalid),
        .out_tready      (out_tready),
        .out_tdata       (out_tdata),
        .out_tkeep       (out_tkeep),
        .out_tlast       (out_tlast),
        .out_tid         (out_tid),
        .out_tdest       (out_tdest),
        .out_rss_enable  (out_rss_enable),
        .out_rss_entropy (out_rss_entropy),
        .tbl_idx         (tbl_idx),
        .pf_qid          (pf_qid),
        .vf0_qid         (vf0_qid),
        .vf1_qid         (vf1_qid),
        .vf2_qid         (vf2_qid),
        .base_pf         (base_pf),
        .base_vf0        (base_vf0),
        .base_vf1        (base_vf1),
        .base_vf2        (base_vf2)
    );

endmodule

// File: hash2qid/hash2qid_lookup.sv
module hash2qid_lookup (
    input  logic                                  core_clk,
    input  logic                                  reset,

    // input stream
    input  logic                                  in_tvalid,
    output logic                                  in_tready,
    input  logic [stream_pkg::DATA_WID-1:0]       in_tdata,
    input  logic [stream_pkg::KEEP_WID-1:0]       in_tkeep,
    input  logic                                  in_tlast,
    input  logic [stream_pkg::TID_WID-1:0]        in_tid,
    input  logic [stream_pkg::TDEST_WID-1:0]      in_tdest,
    input  logic                                  in_rss_enable,
    input  logic [stream_pkg::ENTROPY_WID-1:0]    in_rss_entropy,

    // output stream
    output logic                                  out_tvalid,
    input  logic                                  out_tready,
    output logic [stream_pkg::DATA_WID-1:0]       out_tdata,
    output logic [stream_pkg::KEEP_WID-1:0]       out_tkeep,
    output logic                                  out_tlast,
    output logic [stream_pkg::TID_WID-1:0]        out_tid,
    output logic [stream_pkg::TDEST_WID-1:0]      out_tdest,
    output logic                                  out_rss_enable,
    output logic [stream_pkg::ENTROPY_WID-1:0]    out_rss_entropy,

    // table interface
    output logic [hash2qid_pkg::TABLE_IDX_WID-1:0] tbl_idx,
    input  logic [hash2qid_pkg::QID_WID-1:0]       pf_qid,
    input  logic [hash2qid_pkg::QID_WID-1:0]       vf0_qid,
    input  logic [hash2qid_pkg::QID_WID-1:0]       vf1_qid,
    input  logic [hash2qid_pkg::QID_WID-1:0]       vf2_qid,
    input  logic [hash2qid_pkg::QID_WID-1:0]       base_pf,
    input  logic [hash2qid_pkg::QID_WID-1:0]       base_vf0,
    input  logic [hash2qid_pkg::QID_WID-1:0]       base_vf1,
    input  logic [hash2qid_pkg::QID_WID-1:0]       base_vf2
);

    // whole pipeline moves together
    logic adv;

    // payload that passes through untouched
    logic [stream_pkg::PASS_WID-1:0] in_pass;

    // stage 1
    logic                             s1_valid;
    logic [stream_pkg::PASS_WID-1:0]  s1_pass;
    logic                             s1_rss_enable;
    hash2qid_pkg::host_if_e           s1_host_if;
    logic [hash2qid_pkg::QID_WID-1:0] s1_pf_qid;
    logic [hash2qid_pkg::QID_WID-1:0] s1_vf0_qid;
    logic [hash2qid_pkg::QID_WID-1:0] s1_vf1_qid;
    logic [hash2qid_pkg::QID_WID-1:0] s1_vf2_qid;

    // stage 2
    logic                             s2_valid;
    logic [stream_pkg::PASS_WID-1:0]  s2_pass;
    logic [hash2qid_pkg::QID_WID-1:0] s2_qid;
    logic [hash2qid_pkg::QID_WID-1:0] s2_base;

    // stage 3
    logic                             s3_valid;
    logic [stream_pkg::PASS_WID-1:0]  s3_pass;
    logic [hash2qid_pkg::QID_WID-1:0] s3_sum;

    // ------------------------------
    // flow control
    // ------------------------------

    // advance when the last stage is empty or drains,
    // bubbles move along with the beats
    assign adv       = !s3_valid || out_tready;
    assign in_tready = adv;

    assign in_pass = {in_tdata, in_tkeep, in_tlast, in_tid, in_tdest};

    always_ff @(posedge core_clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else if (adv) begin
            s1_valid <= in_tvalid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    // ------------------------------
    // stage 1, table read
    // ------------------------------

    // low entropy bits index all four tables
    assign tbl_idx = in_rss_entropy[hash2qid_pkg::TABLE_IDX_WID-1:0];

    always_ff @(posedge core_clk) begin
        if (adv) begin
            s1_pass       <= in_pass;
            s1_rss_enable <= in_rss_enable;
            s1_host_if    <= hash2qid_pkg::host_if_e'(
                in_rss_entropy[stream_pkg::ENTROPY_WID-1 -: hash2qid_pkg::HOST_IF_WID]);
            s1_pf_qid     <= pf_qid;
            s1_vf0_qid    <= vf0_qid;
            s1_vf1_qid    <= vf1_qid;
            s1_vf2_qid    <= vf2_qid;
        end
    end

    // ------------------------------
    // stage 2, select by interface
    // ------------------------------

    always_ff @(posedge core_clk) begin
        if (adv) begin
            s2_pass <= s1_pass;

            // rss disabled maps to the base alone
            if (!s1_rss_enable) begin
                s2_qid <= '0;
            end else begin
                case (s1_host_if)
                    hash2qid_pkg::HOST_PF:  s2_qid <= s1_pf_qid;
                    hash2qid_pkg::HOST_VF0: s2_qid <= s1_vf0_qid;
                    hash2qid_pkg::HOST_VF1: s2_qid <= s1_vf1_qid;
                    default:                s2_qid <= s1_vf2_qid;
                endcase
            end

            case (s1_host_if)
                hash2qid_pkg::HOST_PF:  s2_base <= base_pf;
                hash2qid_pkg::HOST_VF0: s2_base <= base_vf0;
                hash2qid_pkg::HOST_VF1: s2_base <= base_vf1;
                default:                s2_base <= base_vf2;
            endcase
        end
    end

    // ------------------------------
    // stage 3, base offset
    // ------------------------------

    // wraps modulo 4096
    always_ff @(posedge core_clk) begin
        if (adv) begin
            s3_pass <= s2_pass;
            s3_sum  <= s2_qid + s2_base;
        end
    end

    // ------------------------------
    // output
    // ------------------------------

    assign out_tvalid = s3_valid;
    assign {out_tdata, out_tkeep, out_tlast, out_tid, out_tdest} = s3_pass;

    // entropy now carries the queue id
    assign out_rss_enable  = 1'b1;
    assign out_rss_entropy = s3_sum;

endmodule

// File: hash2qid/hash2qid_reg_blk.sv
module hash2qid_reg_blk (
    input  logic                                 core_clk,
    input  logic                                 reset,

    // register bus
    input  logic                                 reg_wr,
    input  logic                                 reg_rd,
    input  logic [hash2qid_pkg::REG_ADDR_WID-1:0] reg_addr,
    input  logic [hash2qid_pkg::QID_WID-1:0]      reg_wdata,
    output logic [hash2qid_pkg::QID_WID-1:0]      reg_rdata,
    output logic                                 reg_rack,

    // lookup side
    input  logic [hash2qid_pkg::TABLE_IDX_WID-1:0] tbl_idx,
    output logic [hash2qid_pkg::QID_WID-1:0]       pf_qid,
    output logic [hash2qid_pkg::QID_WID-1:0]       vf0_qid,
    output logic [hash2qid_pkg::QID_WID-1:0]       vf1_qid,
    output logic [hash2qid_pkg::QID_WID-1:0]       vf2_qid,
    output logic [hash2qid_pkg::QID_WID-1:0]       base_pf,
    output logic [hash2qid_pkg::QID_WID-1:0]       base_vf0,
    output logic [hash2qid_pkg::QID_WID-1:0]       base_vf1,
    output logic [hash2qid_pkg::QID_WID-1:0]       base_vf2
);

    // one queue table per host interface
    logic [hash2qid_pkg::QID_WID-1:0] tbl_mem
        [hash2qid_pkg::NUM_HOST_IF][hash2qid_pkg::TABLE_DEPTH];

    // base offsets, host_if_e order
    logic [hash2qid_pkg::QID_WID-1:0] base_reg [hash2qid_pkg::NUM_HOST_IF];

    // decode results
    logic                                   tbl_hit;
    hash2qid_pkg::host_if_e                 tbl_sel;
    logic [hash2qid_pkg::TABLE_IDX_WID-1:0] tbl_word;
    logic                                   base_hit;
    hash2qid_pkg::host_if_e                 base_sel;

    // ------------------------------
    // address decode
    // ------------------------------

    assign tbl_word = reg_addr[hash2qid_pkg::TABLE_IDX_WID-1:0];

    // upper address bits pick the table window
    always_comb begin
        tbl_hit = 1'b1;
        tbl_sel = hash2qid_pkg::HOST_PF;
        case (reg_addr[hash2qid_pkg::REG_ADDR_WID-1:hash2qid_pkg::TABLE_IDX_WID])
            hash2qid_pkg::PF_TABLE_BASE[
                hash2qid_pkg::REG_ADDR_WID-1:hash2qid_pkg::TABLE_IDX_WID]:
                tbl_sel = hash2qid_pkg::HOST_PF;
            hash2qid_pkg::VF0_TABLE_BASE[
                hash2qid_pkg::REG_ADDR_WID-1:hash2qid_pkg::TABLE_IDX_WID]:
                tbl_sel = hash2qid_pkg::HOST_VF0;
            hash2qid_pkg::VF1_TABLE_BASE[
                hash2qid_pkg::REG_ADDR_WID-1:hash2qid_pkg::TABLE_IDX_WID]:
                tbl_sel = hash2qid_pkg::HOST_VF1;
            hash2qid_pkg::VF2_TABLE_BASE[
                hash2qid_pkg::REG_ADDR_WID-1:hash2qid_pkg::TABLE_IDX_WID]:
                tbl_sel = hash2qid_pkg::HOST_VF2;
            default:
                tbl_hit = 1'b0;
        endcase
    end

    // four base words starting at Q_BASE_ADDR
    assign base_hit =
        (reg_addr[hash2qid_pkg::REG_ADDR_WID-1:hash2qid_pkg::HOST_IF_WID] ==
         hash2qid_pkg::Q_BASE_ADDR[hash2qid_pkg::REG_ADDR_WID-1:hash2qid_pkg::HOST_IF_WID]);
    assign base_sel = hash2qid_pkg::host_if_e'(reg_addr[hash2qid_pkg::HOST_IF_WID-1:0]);

    // ------------------------------
    // write path
    // ------------------------------

    // table memory, no reset
    always_ff @(posedge core_clk) begin
        if (reg_wr && tbl_hit) begin
            tbl_mem[tbl_sel][tbl_word] <= reg_wdata;
        end
    end

    always_ff @(posedge core_clk) begin
        if (reset) begin
            for (int i = 0; i < hash2qid_pkg::NUM_HOST_IF; i++) begin
                base_reg[i] <= '0;
            end
        end else if (reg_wr && base_hit) begin
            base_reg[base_sel] <= reg_wdata;
        end
    end

    // ------------------------------
    // read path
    // ------------------------------

    // ack follows the strobe by one cycle
    always_ff @(posedge core_clk) begin
        if (reset) begin
            reg_rack <= 1'b0;
        end else begin
            reg_rack <= reg_rd;
        end
    end

    // unmapped addresses read zero
    always_ff @(posedge core_clk) begin
        if (reg_rd) begin
            if (tbl_hit) begin
                reg_rdata <= tbl_mem[tbl_sel][tbl_word];
            end else if (base_hit) begin
                reg_rdata <= base_reg[base_sel];
            end else begin
                reg_rdata <= '0;
            end
        end
    end

    // ------------------------------
    // lookup side
    // ------------------------------

    // all four tables read at the same index
    assign pf_qid  = tbl_mem[hash2qid_pkg::HOST_PF][tbl_idx];
    assign vf0_qid = tbl_mem[hash2qid_pkg::HOST_VF0][tbl_idx];
    assign vf1_qid = tbl_mem[hash2qid_pkg::HOST_VF1][tbl_idx];
    assign vf2_qid = tbl_mem[hash2qid_pkg::HOST_VF2][tbl_idx];

    assign base_pf  = base_reg[hash2qid_pkg::HOST_PF];
    assign base_vf0 = base_reg[hash2qid_pkg::HOST_VF0];
    assign base_vf1 = base_reg[hash2qid_pkg::HOST_VF1];
    assign base_vf2 = base_reg[hash2qid_pkg::HOST_VF2];

endmodule

// File: common/hash2qid_pkg.sv
package hash2qid_pkg;

    // ------------------------------
    // host interfaces
    // ------------------------------

    // taken from the top entropy bits
    localparam int HOST_IF_WID = 2;
    localparam int NUM_HOST_IF = 2 ** HOST_IF_WID;

    typedef enum logic [HOST_IF_WID-1:0] {
        HOST_PF  = 2'd0,
        HOST_VF0 = 2'd1,
        HOST_VF1 = 2'd2,
        HOST_VF2 = 2'd3
    } host_if_e;

    // ------------------------------
    // queue tables
    // ------------------------------

    localparam int QID_WID       = 12;
    localparam int TABLE_DEPTH   = 128;
    localparam int TABLE_IDX_WID = $clog2(TABLE_DEPTH);

    // ------------------------------
    // register map
    // ------------------------------

    // word addresses
    localparam int REG_ADDR_WID = 10;

    // one table per 128-word window
    localparam logic [REG_ADDR_WID-1:0] PF_TABLE_BASE  = 10'h000;
    localparam logic [REG_ADDR_WID-1:0] VF0_TABLE_BASE = 10'h080;
    localparam logic [REG_ADDR_WID-1:0] VF1_TABLE_BASE = 10'h100;
    localparam logic [REG_ADDR_WID-1:0] VF2_TABLE_BASE = 10'h180;

    // base registers, one per interface in host_if_e order
    localparam logic [REG_ADDR_WID-1:0] Q_BASE_ADDR = 10'h200;

endpackage

// File: common/stream_pkg.sv
package stream_pkg;

    // ------------------------------
    // packet stream widths
    // ------------------------------

    // bytes carried per beat
    localparam int DATA_BYTE_WID = 8;

    // tdata is one byte lane per tkeep bit
    localparam int DATA_WID = DATA_BYTE_WID * 8;
    localparam int KEEP_WID = DATA_BYTE_WID;

    // sideband fields
    localparam int TID_WID   = 4;
    localparam int TDEST_WID = 4;

    // ------------------------------
    // per-beat metadata
    // ------------------------------

    // rss entropy field, replaced by the queue id on output
    localparam int ENTROPY_WID = 12;

    // ------------------------------
    // pass-through payload
    // ------------------------------

    // fields that travel untouched through the pipeline,
    // packed as {tdata, tkeep, tlast, tid, tdest}
    localparam int PASS_WID = DATA_WID
                            + KEEP_WID
                            + 1
                            + TID_WID
                            + TDEST_WID;

endpackage
